//--- hdl/fwrisc_pkg.sv
// RV32I core definitions
package fwrisc_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// Two-state so the bus valids are clean before the first edge
	typedef enum bit [2:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEMR,
		MEMW
	} phase_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SLL,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	typedef enum logic [1:0] {
		CMP_EQ,
		CMP_LT,
		CMP_LTU
	} cmp_op_e;

	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	// Branch offset bits are scattered
	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0] rd;
		logic [6:0] opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10_1;
		logic imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_u;

endpackage

//--- hdl/fwrisc_exec_if.sv
// Controller to datapath bundle
interface fwrisc_exec_if;
	import fwrisc_pkg::*;

	phase_e phase;
	instr_u instr;
	word_t pc;
	logic is_load;
	logic is_store;
	logic is_jump;
	logic is_branch;
	word_t alu_result;
	logic cmp_true; // Already inverted for BNE/BGE/BGEU

	modport control (
		output phase, instr, pc,
		input is_load, is_store, is_jump, is_branch, alu_result, cmp_true
	);

	modport decode (
		input phase, instr, pc, alu_result, cmp_true,
		output is_load, is_store, is_jump, is_branch
	);

	modport exec (
		input phase, instr, pc, is_load, is_store, is_jump, is_branch, alu_result, cmp_true
	);

endinterface

//--- hdl/fwrisc_control.sv
// Phase sequencer and program counter
module fwrisc_control #(
	parameter fwrisc_pkg::word_t RESET_VECTOR = 32'h8000_0000
) (
	input logic clock,
	input logic reset,
	input fwrisc_pkg::word_t idata,
	input logic iready,
	input logic dready,
	output fwrisc_pkg::word_t iaddr,
	output logic ivalid,
	output logic dvalid,
	output logic dwrite,
	fwrisc_exec_if.control ex
);
	import fwrisc_pkg::*;

	word_t pc_next;
	logic taken;

	assign iaddr = ex.pc;
	assign ivalid = (ex.phase == FETCH) && !reset; // Phase reads FETCH while in reset
	assign dvalid = (ex.phase == MEMR) || (ex.phase == MEMW);
	assign dwrite = (ex.phase == MEMW);

	// Jumps and taken branches go to the ALU target
	assign taken = ex.is_jump || (ex.is_branch && ex.cmp_true);
	assign pc_next = taken ? {ex.alu_result[XLEN-1:1], 1'b0} : ex.pc + 32'd4;

	always_ff @(posedge clock) begin
		if (reset) begin
			ex.phase <= FETCH;
			ex.pc <= RESET_VECTOR;
		end else begin
			case (ex.phase)
				FETCH: begin
					if (ivalid && iready) begin
						ex.phase <= DECODE;
					end
				end
				DECODE: ex.phase <= EXECUTE; // Operands settle
				EXECUTE: begin
					if (ex.is_load) begin
						ex.phase <= MEMR;
					end else if (ex.is_store) begin
						ex.phase <= MEMW;
					end else begin
						ex.pc <= pc_next;
						ex.phase <= FETCH;
					end
				end
				MEMR, MEMW: begin
					if (dready) begin // Wait out data-bus stalls
						ex.pc <= pc_next;
						ex.phase <= FETCH;
					end
				end
				default: ex.phase <= FETCH;
			endcase
		end
	end

	// Instruction register
	always_ff @(posedge clock) begin
		if (ivalid && iready) begin
			ex.instr <= idata;
		end
	end

endmodule

//--- hdl/fwrisc_decode.sv
// Instruction decode and writeback select
module fwrisc_decode (
	fwrisc_exec_if.decode ex,
	output fwrisc_pkg::reg_addr_t ra_addr,
	output fwrisc_pkg::reg_addr_t rb_addr,
	output fwrisc_pkg::reg_addr_t rd_addr,
	output logic rd_wen,
	output fwrisc_pkg::word_t rd_wdata,
	output fwrisc_pkg::word_t alu_a,
	output fwrisc_pkg::word_t alu_b,
	output fwrisc_pkg::alu_op_e alu_op,
	output fwrisc_pkg::word_t cmp_b,
	output fwrisc_pkg::cmp_op_e cmp_op,
	output logic cmp_invert,
	input fwrisc_pkg::word_t ra_data,
	input fwrisc_pkg::word_t rb_data,
	input fwrisc_pkg::word_t load_data,
	input logic dready
);
	import fwrisc_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic op_imm;
	logic op_reg;
	logic op_lui;
	logic op_auipc;
	logic op_jal;
	logic op_jalr;
	logic writes_rd;
	logic is_slt;
	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;

	assign opcode = ex.instr.r.opcode;
	assign funct3 = ex.instr.r.funct3;

	assign imm_i = {{20{ex.instr.i.imm[11]}}, ex.instr.i.imm};
	assign imm_s = {{20{ex.instr.s.imm_hi[6]}}, ex.instr.s.imm_hi, ex.instr.s.imm_lo};
	assign imm_b = {{19{ex.instr.b.imm12}}, ex.instr.b.imm12, ex.instr.b.imm11,
		ex.instr.b.imm10_5, ex.instr.b.imm4_1, 1'b0};
	assign imm_u = {ex.instr.u.imm, 12'h000};
	assign imm_j = {{11{ex.instr.j.imm20}}, ex.instr.j.imm20, ex.instr.j.imm19_12,
		ex.instr.j.imm11, ex.instr.j.imm10_1, 1'b0};

	assign op_imm = (opcode == OPC_OP_IMM);
	assign op_reg = (opcode == OPC_OP);
	assign op_lui = (opcode == OPC_LUI);
	assign op_auipc = (opcode == OPC_AUIPC);
	assign op_jal = (opcode == OPC_JAL);
	assign op_jalr = (opcode == OPC_JALR);
	assign ex.is_load = (opcode == OPC_LOAD);
	assign ex.is_store = (opcode == OPC_STORE);
	assign ex.is_branch = (opcode == OPC_BRANCH);
	assign ex.is_jump = op_jal || op_jalr;

	// rs1, rs2 and rd sit in the same place in every format
	assign ra_addr = ex.instr.r.rs1;
	assign rb_addr = ex.instr.r.rs2;
	assign rd_addr = ex.instr.r.rd;

	always_comb begin
		alu_a = ra_data;
		alu_b = imm_i;
		alu_op = ALU_ADD;
		if (op_lui) begin
			alu_a = 32'h0;
			alu_b = imm_u;
		end else if (op_auipc) begin
			alu_a = ex.pc;
			alu_b = imm_u;
		end else if (op_jal) begin
			alu_a = ex.pc;
			alu_b = imm_j;
		end else if (ex.is_branch) begin
			alu_a = ex.pc; // Branch target
			alu_b = imm_b;
		end else if (ex.is_store) begin
			alu_b = imm_s;
		end else if (op_imm || op_reg) begin
			if (op_reg) begin
				alu_b = (funct3 == 3'b000 && ex.instr.r.funct7[5]) ? -rb_data : rb_data;
			end else if (funct3[1:0] == 2'b01) begin
				alu_b = {27'h0, ex.instr.i.imm[4:0]}; // shamt only
			end
			case (funct3)
				3'b001: alu_op = ALU_SLL;
				3'b100: alu_op = ALU_XOR;
				3'b101: alu_op = ex.instr.r.funct7[5] ? ALU_SRA : ALU_SRL;
				3'b110: alu_op = ALU_OR;
				3'b111: alu_op = ALU_AND;
				default: alu_op = ALU_ADD;
			endcase
		end
	end

	// SLT(U) and branches share the comparator
	assign cmp_b = op_imm ? imm_i : rb_data;
	assign cmp_invert = ex.is_branch && funct3[0];

	always_comb begin
		if (ex.is_branch) begin
			case (funct3[2:1])
				2'b00: cmp_op = CMP_EQ;
				2'b10: cmp_op = CMP_LT;
				default: cmp_op = CMP_LTU;
			endcase
		end else begin
			cmp_op = (funct3 == 3'b010) ? CMP_LT : CMP_LTU;
		end
	end

	assign is_slt = (op_imm || op_reg) && (funct3[2:1] == 2'b01);
	assign writes_rd = op_imm || op_reg || op_lui || op_auipc || ex.is_jump;

	always_comb begin
		if (ex.is_jump) begin
			rd_wdata = ex.pc + 32'd4; // Link address
		end else if (ex.is_load) begin
			rd_wdata = load_data;
		end else if (is_slt) begin
			rd_wdata = {31'h0, ex.cmp_true};
		end else begin
			rd_wdata = ex.alu_result;
		end
	end

	// Loads write only on the data handshake
	assign rd_wen = (rd_addr != '0) &&
		((ex.phase == EXECUTE && writes_rd) || (ex.phase == MEMR && dready));

endmodule

//--- hdl/fwrisc_regfile.sv
// Integer register file
module fwrisc_regfile (
	input logic clock,
	input fwrisc_pkg::reg_addr_t ra_addr,
	input fwrisc_pkg::reg_addr_t rb_addr,
	input fwrisc_pkg::reg_addr_t rd_addr,
	input logic rd_wen,
	input fwrisc_pkg::word_t rd_wdata,
	output fwrisc_pkg::word_t ra_data,
	output fwrisc_pkg::word_t rb_data
);
	import fwrisc_pkg::*;

	word_t regs [0:(1 << REG_ADDR_W)-1];

	always_ff @(posedge clock) begin
		if (rd_wen && rd_addr != '0) begin
			regs[rd_addr] <= rd_wdata;
		end
	end

	// x0 is hardwired
	assign ra_data = (ra_addr == '0) ? '0 : regs[ra_addr];
	assign rb_data = (rb_addr == '0) ? '0 : regs[rb_addr];

endmodule

//--- hdl/fwrisc_alu.sv
// ALU with branch comparator
module fwrisc_alu (
	input fwrisc_pkg::word_t alu_a,
	input fwrisc_pkg::word_t alu_b,
	input fwrisc_pkg::alu_op_e alu_op,
	input fwrisc_pkg::word_t cmp_a,
	input fwrisc_pkg::word_t cmp_b,
	input fwrisc_pkg::cmp_op_e cmp_op,
	input logic cmp_invert,
	fwrisc_exec_if ex
);
	import fwrisc_pkg::*;

	logic [4:0] shamt;
	logic cmp_raw;

	assign shamt = alu_b[4:0];

	// SUB arrives as an add of the negated operand
	always_comb begin
		case (alu_op)
			ALU_ADD: ex.alu_result = alu_a + alu_b;
			ALU_SLL: ex.alu_result = alu_a << shamt;
			ALU_XOR: ex.alu_result = alu_a ^ alu_b;
			ALU_SRL: ex.alu_result = alu_a >> shamt;
			ALU_SRA: ex.alu_result = $signed(alu_a) >>> shamt;
			ALU_OR: ex.alu_result = alu_a | alu_b;
			ALU_AND: ex.alu_result = alu_a & alu_b;
			default: ex.alu_result = alu_a + alu_b;
		endcase
	end

	always_comb begin
		case (cmp_op)
			CMP_EQ: cmp_raw = (cmp_a == cmp_b);
			CMP_LT: cmp_raw = ($signed(cmp_a) < $signed(cmp_b));
			default: cmp_raw = (cmp_a < cmp_b); // Unsigned
		endcase
	end

	// BNE, BGE and BGEU take the opposite sense
	assign ex.cmp_true = cmp_raw ^ cmp_invert;

endmodule

//--- hdl/fwrisc_lsu.sv
// Load/store lane handling
module fwrisc_lsu (
	fwrisc_exec_if.exec ex,
	input fwrisc_pkg::word_t store_data,
	input fwrisc_pkg::word_t drdata,
	output fwrisc_pkg::word_t daddr,
	output fwrisc_pkg::word_t dwdata,
	output logic [3:0] dstrb,
	output fwrisc_pkg::word_t load_data
);
	import fwrisc_pkg::*;

	logic [2:0] funct3;
	logic [1:0] lane;
	logic sign_ext;
	word_t shifted;

	assign funct3 = ex.instr.s.funct3;
	assign lane = ex.alu_result[1:0];
	assign daddr = {ex.alu_result[XLEN-1:2], 2'b00}; // Always the aligned word

	// Replicate into every lane and let the strobes pick
	always_comb begin
		case (funct3[1:0])
			2'b00: begin
				dwdata = {4{store_data[7:0]}};
				dstrb = 4'b0001 << lane;
			end
			2'b01: begin
				dwdata = {2{store_data[15:0]}};
				dstrb = 4'b0011 << {lane[1], 1'b0};
			end
			default: begin
				dwdata = store_data;
				dstrb = 4'b1111;
			end
		endcase
	end

	assign shifted = drdata >> {lane, 3'b000};
	assign sign_ext = !funct3[2]; // LBU and LHU set bit 2

	always_comb begin
		case (funct3[1:0])
			2'b00: load_data = {{24{sign_ext && shifted[7]}}, shifted[7:0]};
			2'b01: load_data = {{16{sign_ext && shifted[15]}}, shifted[15:0]};
			default: load_data = drdata;
		endcase
	end

endmodule

//--- hdl/fwrisc_core.sv
// Multi-cycle RV32I core
module fwrisc_core #(
	parameter fwrisc_pkg::word_t RESET_VECTOR = 32'h8000_0000
) (
	input logic clock,
	input logic reset,

	output fwrisc_pkg::word_t iaddr,
	input fwrisc_pkg::word_t idata,
	output logic ivalid,
	input logic iready,

	output fwrisc_pkg::word_t daddr,
	output fwrisc_pkg::word_t dwdata,
	input fwrisc_pkg::word_t drdata,
	output logic [3:0] dstrb,
	output logic dwrite,
	output logic dvalid,
	input logic dready
);
	import fwrisc_pkg::*;

	reg_addr_t ra_addr;
	reg_addr_t rb_addr;
	reg_addr_t rd_addr;
	logic rd_wen;
	word_t rd_wdata;
	word_t ra_data;
	word_t rb_data;
	word_t alu_a;
	word_t alu_b;
	alu_op_e alu_op;
	word_t cmp_b;
	cmp_op_e cmp_op;
	logic cmp_invert;
	word_t load_data;

	fwrisc_exec_if ex ();

	fwrisc_control #(
		.RESET_VECTOR(RESET_VECTOR)
	) u_control (
		.clock(clock),
		.reset(reset),
		.idata(idata),
		.iready(iready),
		.dready(dready),
		.iaddr(iaddr),
		.ivalid(ivalid),
		.dvalid(dvalid),
		.dwrite(dwrite),
		.ex(ex.control)
	);

	fwrisc_decode u_decode (
		.ex(ex.decode),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.rd_addr(rd_addr),
		.rd_wen(rd_wen),
		.rd_wdata(rd_wdata),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.alu_op(alu_op),
		.cmp_b(cmp_b),
		.cmp_op(cmp_op),
		.cmp_invert(cmp_invert),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.load_data(load_data),
		.dready(dready)
	);

	fwrisc_regfile u_regfile (
		.clock(clock),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.rd_addr(rd_addr),
		.rd_wen(rd_wen),
		.rd_wdata(rd_wdata),
		.ra_data(ra_data),
		.rb_data(rb_data)
	);

	fwrisc_alu u_alu (
		.alu_a(alu_a),
		.alu_b(alu_b),
		.alu_op(alu_op),
		.cmp_a(ra_data), // Compares always take rs1
		.cmp_b(cmp_b),
		.cmp_op(cmp_op),
		.cmp_invert(cmp_invert),
		.ex(ex)
	);

	fwrisc_lsu u_lsu (
		.ex(ex.exec),
		.store_data(rb_data),
		.drdata(drdata),
		.daddr(daddr),
		.dwdata(dwdata),
		.dstrb(dstrb),
		.load_data(load_data)
	);

endmodule

//--- testbench/fwrisc_core_sva.sv
// Core bus protocol assertions
module fwrisc_core_sva (
	input logic clock,
	input logic reset,
	input logic [31:0] iaddr,
	input logic ivalid,
	input logic iready,
	input logic [31:0] daddr,
	input logic [31:0] dwdata,
	input logic [3:0] dstrb,
	input logic dwrite,
	input logic dvalid,
	input logic dready
);

	// No requests while held in reset
	a_quiet_in_reset: assert property (@(posedge clock) reset |-> !ivalid && !dvalid)
		else $error("bus request during reset");

	a_ibus_hold: assert property (@(posedge clock) disable iff (reset)
		ivalid && !iready |=> ivalid && $stable(iaddr))
		else $error("instruction request dropped or changed before iready");

	a_dbus_hold: assert property (@(posedge clock) disable iff (reset)
		dvalid && !dready |=> dvalid && $stable(daddr) && $stable(dwrite)
			&& $stable(dstrb) && $stable(dwdata))
		else $error("data request dropped or changed before dready");

	// One instruction in flight
	a_one_bus: assert property (@(posedge clock) !(ivalid && dvalid))
		else $error("instruction and data requests together");

endmodule

bind fwrisc_core fwrisc_core_sva sva (.*);

//--- testbench/fwrisc_core_tb.sv
// Core testbench
module fwrisc_core_tb;
	import fwrisc_pkg::*;

	logic clock;
	logic reset;
	word_t iaddr, idata, daddr, dwdata, drdata;
	logic ivalid, iready, dvalid, dready, dwrite;
	logic [3:0] dstrb;

	word_t prog [4][128];
	int plen [4];
	word_t dmem [0:255];
	int cur, seed, errors, cycles, limit, fetches;
	logic stall_en, done;
	word_t sig, sig_ref [4];

	// Model state
	word_t m_pc;
	word_t m_regs [32];
	word_t m_mem [0:255];
	logic exp_pend, exp_write;
	word_t exp_addr, exp_wdata;
	logic [3:0] exp_strb;

	fwrisc_core #(.RESET_VECTOR(32'h0)) uut (.*);

	initial begin
		clock = 0;
		forever #5 clock = ~clock;
	end

	assign idata = prog[cur][iaddr[8:2]];
	assign drdata = dmem[daddr[9:2]];

	function automatic word_t fill_word(int i);
		return (i * 32'h9E37_79B1) ^ {i[7:0], ~i[7:0], i[7:0], 8'h5A};
	endfunction

	function automatic int rnd(int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// One instruction of the ISA model
	function automatic void ref_step(word_t ins);
		logic [4:0] rd, rs1, rs2;
		logic [2:0] f3;
		word_t a, b, y, res, npc, ea, w;
		logic wr, tk;
		rd = ins[11:7];
		f3 = ins[14:12];
		rs1 = ins[19:15];
		rs2 = ins[24:20];
		a = m_regs[rs1];
		b = m_regs[rs2];
		npc = m_pc + 4;
		wr = 1'b0;
		res = '0;
		case (ins[6:0])
			OPC_LUI: {wr, res} = {1'b1, ins[31:12], 12'h0};
			OPC_AUIPC: {wr, res} = {1'b1, m_pc + {ins[31:12], 12'h0}};
			OPC_JAL: begin
				{wr, res} = {1'b1, m_pc + 32'd4};
				npc = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			end
			OPC_JALR: begin
				{wr, res} = {1'b1, m_pc + 32'd4};
				npc = (a + {{20{ins[31]}}, ins[31:20]}) & ~32'd1;
			end
			OPC_BRANCH: begin
				case (f3)
					3'd0: tk = (a == b);
					3'd1: tk = (a != b);
					3'd4: tk = ($signed(a) < $signed(b));
					3'd5: tk = ($signed(a) >= $signed(b));
					3'd6: tk = (a < b);
					default: tk = (a >= b);
				endcase
				if (tk)
					npc = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			end
			OPC_OP, OPC_OP_IMM: begin
				y = (ins[6:0] == OPC_OP) ? b : {{20{ins[31]}}, ins[31:20]};
				wr = 1'b1;
				case (f3)
					3'd0: res = (ins[6:0] == OPC_OP && ins[30]) ? a - y : a + y;
					3'd1: res = a << y[4:0];
					3'd2: res = {31'h0, $signed(a) < $signed(y)};
					3'd3: res = {31'h0, a < y};
					3'd4: res = a ^ y;
					3'd5: begin
						if (ins[30])
							res = $signed(a) >>> y[4:0]; // Sign bit fills from the top
						else
							res = a >> y[4:0];
					end
					3'd6: res = a | y;
					default: res = a & y;
				endcase
			end
			OPC_LOAD, OPC_STORE: begin
				if (ins[6:0] == OPC_LOAD)
					ea = a + {{20{ins[31]}}, ins[31:20]};
				else
					ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
				exp_pend = 1'b1;
				exp_write = (ins[6:0] == OPC_STORE);
				exp_addr = {ea[31:2], 2'b00};
				case (f3[1:0])
					2'd0: {exp_strb, exp_wdata} = {4'b0001 << ea[1:0], {4{b[7:0]}}};
					2'd1: {exp_strb, exp_wdata} = {4'b0011 << {ea[1], 1'b0}, {2{b[15:0]}}};
					default: {exp_strb, exp_wdata} = {4'b1111, b};
				endcase
				w = m_mem[ea[9:2]];
				if (exp_write) begin
					for (int k = 0; k < 4; k++)
						if (exp_strb[k]) w[8*k +: 8] = exp_wdata[8*k +: 8];
					m_mem[ea[9:2]] = w;
				end else begin
					wr = 1'b1;
					w = w >> (8 * ea[1:0]);
					case (f3)
						3'd0: res = {{24{w[7]}}, w[7:0]};
						3'd1: res = {{16{w[15]}}, w[15:0]};
						3'd4: res = {24'h0, w[7:0]};
						3'd5: res = {16'h0, w[15:0]};
						default: res = m_mem[ea[9:2]];
					endcase
				end
			end
			default: ; // FENCE and system are no-ops
		endcase
		if (wr && rd != 0) m_regs[rd] = res;
		m_pc = npc;
	endfunction

	task automatic check_val(string name, word_t got, word_t exp);
		if (got !== exp) begin
			$display("** Error: %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// Comparator
	always @(posedge clock) begin
		if (!reset && !done) begin
			if (ivalid && iready) begin
				check_val("iaddr", iaddr, m_pc);
				if (exp_pend) begin
					$display("Fetch at %h before the expected data access", iaddr);
					errors++;
					exp_pend = 1'b0;
				end
				fetches++;
				if (iaddr == 4 * (plen[cur] - 1))
					done = 1'b1;
				else
					ref_step(idata);
			end
			if (dvalid && dready) begin
				if (!exp_pend) begin
					$display("Data access at %h with no memory instruction pending", daddr);
					errors++;
				end else begin
					check_val("daddr", daddr, exp_addr);
					check_val("dwrite", dwrite, exp_write);
					check_val("dstrb", dstrb, exp_strb);
					if (exp_write) check_val("dwdata", dwdata, exp_wdata);
				end
				exp_pend = 1'b0;
			end
		end
	end

	// Data memory with byte strobes
	always @(posedge clock) begin
		if (dvalid && dready && dwrite) begin
			for (int k = 0; k < 4; k++)
				if (dstrb[k]) dmem[daddr[9:2]][8*k +: 8] <= dwdata[8*k +: 8];
			sig <= {sig[30:0], sig[31]} ^ dwdata ^ daddr ^ dstrb;
		end
	end

	always @(posedge clock) begin
		iready <= stall_en ? (rnd(4) != 0) : 1'b1;
		dready <= stall_en ? (rnd(3) != 0) : 1'b1;
		cycles++;
		if (cycles > limit) begin
			$display("Timeout after %0d cycles without finishing the program", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	function automatic word_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	task automatic emit(int t, word_t w);
		prog[t][plen[t]] = w;
		plen[t]++;
	endtask

	task automatic init_regs(int t);
		for (int r = 1; r <= 12; r++) begin
			emit(t, {20'($random(seed)), 5'(r), OPC_LUI});
			emit(t, enc_i(12'($random(seed)), 5'(r), 3'd0, 5'(r), OPC_OP_IMM));
		end
		emit(t, enc_i(12'h100, 5'd0, 3'd0, 5'd31, OPC_OP_IMM)); // Data base
	endtask

	task automatic store_regs(int t, int first, int last, int offset);
		for (int r = first; r <= last; r++)
			emit(t, enc_s(12'(offset + 4 * r), 5'(r), 5'd31, 3'd2));
	endtask

	task automatic gen_programs();
		logic [2:0] f3;
		logic [11:0] imm;
		for (int t = 0; t < 4; t++) begin
			plen[t] = 0;
			init_regs(t);
		end
		for (int n = 0; n < 20; n++) begin
			f3 = 3'(rnd(8));
			imm = (f3 == 1 || f3 == 5) ? {1'b0, 1'(rnd(2)), 5'h0, 5'(rnd(32))} : 12'(rnd(4096));
			if (rnd(2) != 0)
				emit(0, {1'b0, (f3 == 0 || f3 == 5) ? 1'(rnd(2)) : 1'b0, 5'h0, 5'(1 + rnd(12)),
					5'(1 + rnd(12)), f3, 5'(1 + rnd(12)), OPC_OP});
			else
				emit(0, enc_i(imm, 5'(1 + rnd(12)), f3, 5'(1 + rnd(12)), OPC_OP_IMM));
		end
		store_regs(0, 1, 12, 0);
		emit(1, {20'($random(seed)), 5'd1, OPC_LUI});
		emit(1, {20'($random(seed)), 5'd2, OPC_AUIPC});
		emit(1, {1'b0, 10'd4, 1'b0, 8'd0, 5'd3, OPC_JAL}); // Skips one
		emit(1, enc_i(12'd1, 5'd0, 3'd0, 5'd4, OPC_OP_IMM));
		emit(1, enc_i(12'd13, 5'd3, 3'd0, 5'd5, OPC_JALR)); // Odd target, bit 0 cleared
		emit(1, enc_i(12'd7, 5'd0, 3'd0, 5'd6, OPC_OP_IMM));
		store_regs(1, 1, 6, 0);
		for (int n = 0; n < 18; n++) begin
			f3 = (n % 6 < 2) ? 3'(n % 6) : 3'(n % 6 + 2);
			emit(2, enc_i(12'(rnd(8) - 4), 5'd0, 3'd0, 5'd1, OPC_OP_IMM));
			emit(2, enc_i(12'(rnd(8) - 4), 5'd0, 3'd0, 5'd2, OPC_OP_IMM));
			emit(2, {7'h0, 5'd2, 5'd1, f3, 4'd4, 1'b0, OPC_BRANCH}); // Forward 8
			emit(2, enc_i(12'(n + 1), 5'd3, 3'd0, 5'd3, OPC_OP_IMM));
		end
		store_regs(2, 3, 3, 0);
		for (int l = 0; l < 4; l++)
			emit(3, enc_s(12'h40 + l, 5'(l + 1), 5'd31, 3'd0));
		emit(3, enc_s(12'h44, 5'd5, 5'd31, 3'd1));
		emit(3, enc_s(12'h46, 5'd6, 5'd31, 3'd1));
		emit(3, enc_s(12'h48, 5'd7, 5'd31, 3'd2));
		for (int n = 0; n < 16; n++) begin
			f3 = (n < 8) ? ((n < 4) ? 3'd0 : 3'd4) : ((n < 14) ? ((n % 2) ? 3'd5 : 3'd1) : 3'd2);
			imm = (n < 8) ? 12'h40 + n % 4 : ((n < 14) ? 12'h44 + 2 * ((n - 8) / 2 % 2) : 12'h48);
			if (n == 10 || n == 11) imm = 12'h12 + (n - 10) * 12'h20; // Fill pattern
			if (n == 15) imm = 12'h80;
			emit(3, enc_i(imm, 5'd31, f3, 5'd8, OPC_LOAD));
			emit(3, enc_s(12'(12'h80 + 4 * n), 5'd8, 5'd31, 3'd2));
		end
		for (int t = 0; t < 4; t++)
			emit(t, {1'b0, 10'd0, 1'b0, 8'd0, 5'd0, OPC_JAL}); // Park loop
	endtask

	task automatic run_program(int t, logic stalls, string name);
		int errs;
		errs = errors;
		reset <= 1'b1;
		@(posedge clock);
		cur = t;
		stall_en = stalls;
		limit = cycles + 40 * plen[t] + 40;
		done = 1'b0;
		fetches = 0;
		sig = '0;
		exp_pend = 1'b0;
		m_pc = '0;
		for (int r = 0; r < 32; r++) m_regs[r] = '0;
		for (int i = 0; i < 256; i++) begin
			dmem[i] = fill_word(i);
			m_mem[i] = fill_word(i);
		end
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		while (!done) @(posedge clock);
		if (!stalls) sig_ref[t] = sig ^ fetches;
		else if ((sig ^ fetches) !== sig_ref[t]) begin
			$display("Stalled run of program %0d differs from the stall-free run", t);
			errors++;
		end
		$display("%s: %s", name, (errors == errs) ? "ok" : "errors");
	endtask

	initial begin
		reset = 1'b1;
		iready = 1'b0;
		dready = 1'b0;
		stall_en = 1'b0;
		done = 1'b0;
		cur = 0;
		seed = 57861;
		errors = 0;
		cycles = 0;
		limit = 100;
		gen_programs();
		run_program(0, 1'b0, "reset and arithmetic");
		run_program(1, 1'b0, "upper immediates and jumps");
		run_program(2, 1'b0, "branches");
		run_program(3, 1'b0, "loads and stores");
		for (int t = 0; t < 4; t++)
			run_program(t, 1'b1, $sformatf("stalled rerun %0d", t));
		$display("Summary: 8 runs, %0d errors", errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- fwrisc_core.f
hdl/fwrisc_pkg.sv
hdl/fwrisc_exec_if.sv
hdl/fwrisc_control.sv
hdl/fwrisc_decode.sv
hdl/fwrisc_regfile.sv
hdl/fwrisc_alu.sv
hdl/fwrisc_lsu.sv
hdl/fwrisc_core.sv
testbench/fwrisc_core_sva.sv
testbench/fwrisc_core_tb.sv
